//--- cpu_dispatcher.sv
`timescale 1ns/1ps

module cpu_dispatcher
  import dispatch_pkg::*;
  import cpu_msg_pkg::*;
(
  input  logic                   clk,
  input  logic                   ext_rst_e,
  input  logic                   cpu_e,
  input  logic [CPU_MSG_W-1:0]   cpu_msg_in,
  input  logic [ADDR_W-1:0]      addr_in,
  input  logic [DATA_W-1:0]      data_in,
  input  logic                   read_q,
  input  logic                   write_q,
  input  logic [ADDR_W-1:0]      ext_mem_addr_in,
  input  logic [DATA_W-1:0]      ext_mem_data_in,
  input  logic                   ext_read_dn,
  input  logic                   ext_write_dn,
  output logic                   cpu_q,
  output logic [CPU_INDEX_W-1:0] cpu_index,
  output logic [CPU_MSG_W-1:0]   cpu_msg_out,
  output logic [ADDR_W-1:0]      addr_out,
  output logic [DATA_W-1:0]      data_out,
  output logic                   read_dn,
  output logic                   write_dn,
  output logic [ADDR_W-1:0]      ext_mem_addr_out,
  output logic [DATA_W-1:0]      ext_mem_data_out,
  output logic                   ext_read_q,
  output logic                   ext_write_q
);

  cpu_msg_t msg_in;
  logic     start;
  logic     finish;
  logic     roster_advance;

  // raw message bits into the enum domain
  assign msg_in = cpu_msg_t'(cpu_msg_in);

  mem_req_if mem_req ();
  thread_if  thrd ();
  return_if  poll_ret ();
  return_if  mem_ret ();
  return_if  thrd_ret ();

  dispatch_sequencer sequencer_inst (
    .clk            (clk),
    .ext_rst_e      (ext_rst_e),
    .cpu_e          (cpu_e),
    .cpu_msg_in     (msg_in),
    .read_q         (read_q),
    .write_q        (write_q),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .cpu_q          (cpu_q),
    .read_dn        (read_dn),
    .write_dn       (write_dn),
    .mem            (mem_req),
    .thrd           (thrd),
    .poll_ret       (poll_ret),
    .start          (start),
    .finish         (finish),
    .roster_advance (roster_advance),
    .cpu_index      (cpu_index)
  );

  cpu_roster roster_inst (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .advance   (roster_advance),
    .start     (start),
    .finish    (finish),
    .cpu_index (cpu_index)
  );

  mem_relay relay_inst (
    .clk              (clk),
    .ext_rst_e        (ext_rst_e),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .req              (mem_req),
    .ret              (mem_ret)
  );

  thread_table thread_table_inst (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .ctl       (thrd),
    .ret       (thrd_ret)
  );

  return_bus_arbiter arbiter_inst (
    .mem_ret     (mem_ret),
    .thrd_ret    (thrd_ret),
    .poll_ret    (poll_ret),
    .addr_out    (addr_out),
    .data_out    (data_out),
    .cpu_msg_out (cpu_msg_out)
  );

endmodule

//--- cpu_dispatcher_assertions.sv
`timescale 1ns/1ps

module cpu_dispatcher_assertions (
  input logic clk,
  input logic ext_rst_e,
  input logic cpu_q,
  input logic ext_read_q,
  input logic ext_write_q,
  input logic read_dn,
  input logic write_dn
);

  // poll strobe is a single-cycle pulse
  poll_single_cycle: assert property (
    @(posedge clk) disable iff (ext_rst_e) cpu_q |=> !cpu_q
  ) else $error("cpu_q stayed high for more than one cycle");

  // only one external transfer at a time
  ext_strobes_exclusive: assert property (
    @(posedge clk) disable iff (ext_rst_e) !(ext_read_q && ext_write_q)
  ) else $error("ext_read_q and ext_write_q high together");

  // external strobe lasts one cycle, no done in the same cycle
  ext_strobe_single_cycle: assert property (
    @(posedge clk) disable iff (ext_rst_e)
      (ext_read_q || ext_write_q) |-> !(read_dn || write_dn) ##1 !(ext_read_q || ext_write_q)
  ) else $error("external strobe longer than one cycle or overlapping a done");

endmodule

bind cpu_dispatcher cpu_dispatcher_assertions assertions_inst (
  .clk         (clk),
  .ext_rst_e   (ext_rst_e),
  .cpu_q       (cpu_q),
  .ext_read_q  (ext_read_q),
  .ext_write_q (ext_write_q),
  .read_dn     (read_dn),
  .write_dn    (write_dn)
);

//--- cpu_msg_pkg.sv
package cpu_msg_pkg;

  localparam int CPU_MSG_W = 4;

  // messages on cpu_msg_in / cpu_msg_out
  typedef enum logic [CPU_MSG_W-1:0] {
    CPU_R_NULL      = 4'd0,
    CPU_R_START     = 4'd1,
    CPU_R_END       = 4'd2,
    CPU_R_FORK_THRD = 4'd3,
    CPU_R_STOP_THRD = 4'd4,
    CPU_R_FORK_DONE = 4'd5,
    CPU_R_STOP_DONE = 4'd6
  } cpu_msg_t;

  // commands into the thread table
  typedef enum logic [1:0] {
    THREAD_CMD_NULL = 2'd0,
    THREAD_CMD_RUN  = 2'd1,
    THREAD_CMD_STOP = 2'd2
  } thrd_cmd_t;

endpackage

//--- cpu_roster.sv
`timescale 1ns/1ps

module cpu_roster
  import dispatch_pkg::*;
(
  input  logic                   clk,
  input  logic                   ext_rst_e,
  input  logic                   advance,
  input  logic                   start,
  input  logic                   finish,
  output logic [CPU_INDEX_W-1:0] cpu_index
);

  logic [CPU_INDEX_W-1:0] active_cnt;
  logic [CPU_INDEX_W-1:0] nonactive_cnt;
  logic [CPU_INDEX_W-1:0] rr_num;
  logic [CPU_INDEX_W-1:0] rr_inc;
  logic [CPU_INDEX_W-1:0] rr_next;
  logic                   just_offered;

  // round robin over active numbers, wraps at the active count
  assign rr_inc  = rr_num + CPU_INDEX_W'(1);
  assign rr_next = (rr_inc >= active_cnt) ? '0 : rr_inc;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      active_cnt    <= '0;
      nonactive_cnt <= CPU_INDEX_W'(CPU_QUANTITY);
      rr_num        <= '0;
      just_offered  <= 1'b0;
      cpu_index     <= '0;
    end else begin
      if (advance) begin
        // start slot every other poll while some cpu is idle
        if (nonactive_cnt != '0 && !just_offered) begin
          cpu_index    <= CPU_NONACTIVE;
          just_offered <= 1'b1;
        end else begin
          rr_num       <= rr_next;
          cpu_index    <= rr_next | CPU_ACTIVE;
          just_offered <= 1'b0;
        end
      end
      // move one cpu between the pools
      if (start && nonactive_cnt != '0) begin
        nonactive_cnt <= nonactive_cnt - CPU_INDEX_W'(1);
        active_cnt    <= active_cnt + CPU_INDEX_W'(1);
      end else if (finish && active_cnt != '0) begin
        active_cnt    <= active_cnt - CPU_INDEX_W'(1);
        nonactive_cnt <= nonactive_cnt + CPU_INDEX_W'(1);
      end
    end
  end

endmodule

//--- dispatch_ifs.sv
`timescale 1ns/1ps

// memory request from the sequencer to the relay
interface mem_req_if import dispatch_pkg::*; ();
  logic              rd;
  logic              wr;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              done;
  logic [ADDR_W-1:0] raddr;
  logic [DATA_W-1:0] rdata;

  modport initiator (output rd, wr, addr, wdata, input done, raddr, rdata);
  modport target (input rd, wr, addr, wdata, output done, raddr, rdata);
endinterface

// fork/stop commands and next-thread rotation
interface thread_if import dispatch_pkg::*; import cpu_msg_pkg::*; ();
  thrd_cmd_t         cmd;
  logic [SLOT_W-1:0] slot;
  logic [ADDR_W-1:0] entry;
  logic              done;
  logic              advance;
  logic [ADDR_W-1:0] next_entry;

  modport initiator (output cmd, slot, entry, advance, input done, next_entry);
  modport target (input cmd, slot, entry, advance, output done, next_entry);
endinterface

// one requester of the shared return bus
interface return_if import dispatch_pkg::*; import cpu_msg_pkg::*; ();
  logic              valid;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  cpu_msg_t          msg;

  modport source (output valid, addr, data, msg);
  modport sink (input valid, addr, data, msg);
endinterface

//--- dispatch_pkg.sv
package dispatch_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  // cpu pool size
  localparam int CPU_QUANTITY = 4;
  localparam int CPU_INDEX_W = 8;

  // top index bit marks an active cpu number
  localparam logic [CPU_INDEX_W-1:0] CPU_ACTIVE = 8'h80;
  // start slot offered to a non-active cpu
  localparam logic [CPU_INDEX_W-1:0] CPU_NONACTIVE = 8'hFF;

  // thread table geometry
  localparam int THREAD_SLOTS = 4;
  localparam int SLOT_W = 2;

  typedef enum logic [1:0] {
    CTL_CPU_LOOP   = 2'd0,
    CTL_CPU_CMD    = 2'd1,
    CTL_MEM_WORK   = 2'd2,
    CTL_THRD_REPLY = 2'd3
  } ctl_state_t;

endpackage

//--- dispatch_sequencer.sv
`timescale 1ns/1ps

module dispatch_sequencer
  import dispatch_pkg::*;
  import cpu_msg_pkg::*;
(
  input  logic                   clk,
  input  logic                   ext_rst_e,
  input  logic                   cpu_e,
  input  cpu_msg_t               cpu_msg_in,
  input  logic                   read_q,
  input  logic                   write_q,
  input  logic [ADDR_W-1:0]      addr_in,
  input  logic [DATA_W-1:0]      data_in,
  output logic                   cpu_q,
  output logic                   read_dn,
  output logic                   write_dn,
  mem_req_if.initiator           mem,
  thread_if.initiator            thrd,
  return_if.source               poll_ret,
  output logic                   start,
  output logic                   finish,
  output logic                   roster_advance,
  input  logic [CPU_INDEX_W-1:0] cpu_index
);

  ctl_state_t state;
  logic       cpu_q_r;
  logic       wr_op;
  logic       in_cmd;
  logic       take_rd;
  logic       take_wr;
  logic       take_ev;
  logic       take_thrd;
  logic       is_thrd_msg;
  logic       offer_start;
  logic       offer_active;

  // command decode, priority read, write, cpu_e, thread message
  assign in_cmd      = state == CTL_CPU_CMD;
  assign is_thrd_msg = cpu_msg_in == CPU_R_FORK_THRD || cpu_msg_in == CPU_R_STOP_THRD;
  assign take_rd     = in_cmd && read_q;
  assign take_wr     = in_cmd && !read_q && write_q;
  assign take_ev     = in_cmd && !read_q && !write_q && cpu_e;
  assign take_thrd   = in_cmd && !read_q && !write_q && !cpu_e && is_thrd_msg;

  // what the current poll offered
  assign offer_start  = cpu_index == CPU_NONACTIVE;
  assign offer_active = !offer_start && ((cpu_index & CPU_ACTIVE) != '0);

  // roster updates only when the answer fits the offer
  assign start  = take_ev && cpu_msg_in == CPU_R_START && offer_start;
  assign finish = take_ev && cpu_msg_in == CPU_R_END && offer_active;

  // one advance per poll, in the cycle before cpu_q
  assign roster_advance = state == CTL_CPU_LOOP;
  assign thrd.advance   = state == CTL_CPU_LOOP;

  // request goes out in the sampling cycle
  assign mem.rd    = take_rd;
  assign mem.wr    = take_wr;
  assign mem.addr  = addr_in;
  assign mem.wdata = data_in;

  // slot number from the address, entry from the data bus
  assign thrd.cmd   = !take_thrd ? THREAD_CMD_NULL :
                      (cpu_msg_in == CPU_R_FORK_THRD) ? THREAD_CMD_RUN : THREAD_CMD_STOP;
  assign thrd.slot  = addr_in[SLOT_W-1:0];
  assign thrd.entry = ADDR_W'(data_in);

  // poll puts the next thread entry on the return bus
  assign poll_ret.valid = cpu_q_r;
  assign poll_ret.addr  = thrd.next_entry;
  assign poll_ret.data  = '0;
  assign poll_ret.msg   = CPU_R_NULL;

  assign cpu_q    = cpu_q_r;
  // done flags line up with the relay reply
  assign read_dn  = state == CTL_MEM_WORK && mem.done && !wr_op;
  assign write_dn = state == CTL_MEM_WORK && mem.done && wr_op;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state   <= CTL_CPU_LOOP;
      cpu_q_r <= 1'b0;
      wr_op   <= 1'b0;
    end else begin
      cpu_q_r <= 1'b0;
      unique case (state)
        CTL_CPU_LOOP: begin
          // roster index settles at this edge
          cpu_q_r <= 1'b1;
          state   <= CTL_CPU_CMD;
        end
        CTL_CPU_CMD: begin
          if (take_rd || take_wr) begin
            wr_op <= take_wr;
            state <= CTL_MEM_WORK;
          end else if (take_ev) begin
            state <= CTL_CPU_LOOP;
          end else if (take_thrd) begin
            state <= CTL_THRD_REPLY;
          end
        end
        CTL_MEM_WORK: begin
          // wait for the external memory through the relay
          if (mem.done) begin
            state <= CTL_CPU_LOOP;
          end
        end
        CTL_THRD_REPLY: begin
          if (thrd.done) begin
            state <= CTL_CPU_LOOP;
          end
        end
      endcase
    end
  end

endmodule

//--- mem_relay.sv
`timescale 1ns/1ps

module mem_relay
  import dispatch_pkg::*;
  import cpu_msg_pkg::*;
(
  input  logic              clk,
  input  logic              ext_rst_e,
  input  logic [ADDR_W-1:0] ext_mem_addr_in,
  input  logic [DATA_W-1:0] ext_mem_data_in,
  input  logic              ext_read_dn,
  input  logic              ext_write_dn,
  output logic [ADDR_W-1:0] ext_mem_addr_out,
  output logic [DATA_W-1:0] ext_mem_data_out,
  output logic              ext_read_q,
  output logic              ext_write_q,
  mem_req_if.target         req,
  return_if.source          ret
);

  logic              pend_rd;
  logic              pend_wr;
  logic              done_r;
  logic              finish_op;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [ADDR_W-1:0] raddr_q;
  logic [DATA_W-1:0] rdata_q;

  // only the done matching the open request counts
  assign finish_op = (pend_rd && ext_read_dn) || (pend_wr && ext_write_dn);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      pend_rd     <= 1'b0;
      pend_wr     <= 1'b0;
      done_r      <= 1'b0;
      ext_read_q  <= 1'b0;
      ext_write_q <= 1'b0;
    end else begin
      // one-cycle strobes
      ext_read_q  <= req.rd;
      ext_write_q <= req.wr;
      done_r      <= finish_op;
      if (req.rd) begin
        pend_rd <= 1'b1;
      end else if (ext_read_dn) begin
        pend_rd <= 1'b0;
      end
      if (req.wr) begin
        pend_wr <= 1'b1;
      end else if (ext_write_dn) begin
        pend_wr <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req.rd || req.wr) begin
      addr_q <= req.addr;
    end
    if (req.wr) begin
      wdata_q <= req.wdata;
    end
    // capture what memory answered
    if (finish_op) begin
      raddr_q <= ext_mem_addr_in;
      rdata_q <= ext_mem_data_in;
    end
  end

  assign ext_mem_addr_out = addr_q;
  assign ext_mem_data_out = wdata_q;

  assign req.done  = done_r;
  assign req.raddr = raddr_q;
  assign req.rdata = rdata_q;

  // reply towards the cpus
  assign ret.valid = done_r;
  assign ret.addr  = raddr_q;
  assign ret.data  = rdata_q;
  assign ret.msg   = CPU_R_NULL;

endmodule

//--- return_bus_arbiter.sv
`timescale 1ns/1ps

module return_bus_arbiter
  import dispatch_pkg::*;
  import cpu_msg_pkg::*;
(
  return_if.sink               mem_ret,
  return_if.sink               thrd_ret,
  return_if.sink               poll_ret,
  output logic [ADDR_W-1:0]    addr_out,
  output logic [DATA_W-1:0]    data_out,
  output logic [CPU_MSG_W-1:0] cpu_msg_out
);

  // fixed priority, memory first, poll last
  always_comb begin
    addr_out    = '0;
    data_out    = '0;
    cpu_msg_out = '0;
    if (mem_ret.valid) begin
      addr_out    = mem_ret.addr;
      data_out    = mem_ret.data;
      cpu_msg_out = mem_ret.msg;
    end else if (thrd_ret.valid) begin
      addr_out    = thrd_ret.addr;
      data_out    = thrd_ret.data;
      cpu_msg_out = thrd_ret.msg;
    end else if (poll_ret.valid) begin
      // poll carries the next thread entry
      addr_out    = poll_ret.addr;
      data_out    = poll_ret.data;
      cpu_msg_out = poll_ret.msg;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cpu_dispatcher -f sources.f
status=0
./obj_dir/Vtb_cpu_dispatcher > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
exit 0

//--- sources.f
dispatch_pkg.sv
cpu_msg_pkg.sv
dispatch_ifs.sv
dispatch_sequencer.sv
cpu_roster.sv
mem_relay.sv
thread_table.sv
return_bus_arbiter.sv
cpu_dispatcher.sv
cpu_dispatcher_assertions.sv
tb_cpu_dispatcher.sv

//--- tb_cpu_dispatcher.sv
`timescale 1ns/1ps

module tb_cpu_dispatcher
  import dispatch_pkg::*;
  import cpu_msg_pkg::*;
();

  localparam int NUM_OPS      = 80;
  localparam int POLL_TIMEOUT = 40;
  localparam int MEM_WORDS    = 16;
  localparam int RESET_CYCLES = 8;

  logic                   clk = 1'b0;
  logic                   ext_rst_e;
  logic                   cpu_e;
  logic [CPU_MSG_W-1:0]   cpu_msg_in;
  logic [ADDR_W-1:0]      addr_in;
  logic [DATA_W-1:0]      data_in;
  logic                   read_q;
  logic                   write_q;
  // memory side inputs belong to the memory model
  logic [ADDR_W-1:0]      ext_mem_addr_in = '0;
  logic [DATA_W-1:0]      ext_mem_data_in = '0;
  logic                   ext_read_dn = 1'b0;
  logic                   ext_write_dn = 1'b0;
  logic                   cpu_q;
  logic [CPU_INDEX_W-1:0] cpu_index;
  logic [CPU_MSG_W-1:0]   cpu_msg_out;
  logic [ADDR_W-1:0]      addr_out;
  logic [DATA_W-1:0]      data_out;
  logic                   read_dn;
  logic                   write_dn;
  logic [ADDR_W-1:0]      ext_mem_addr_out;
  logic [DATA_W-1:0]      ext_mem_data_out;
  logic                   ext_read_q;
  logic                   ext_write_q;

  integer seed;
  int     mem_delay;
  int     mem_wait;
  bit     mem_busy = 1'b0;
  bit     mem_write;
  logic [DATA_W-1:0] ext_mem [MEM_WORDS];
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];

  // roster and thread model state
  int                      m_active;
  int                      m_nonactive;
  int                      m_rr;
  bit                      m_offered;
  logic [CPU_INDEX_W-1:0]  m_last_index;
  int                      m_ptr;
  logic [THREAD_SLOTS-1:0] m_running;
  logic [ADDR_W-1:0]       m_entry [THREAD_SLOTS];

  // expected responses, oldest first
  logic [32:0] exp_poll_q[$];
  logic [32:0] exp_mem_q[$];
  logic [32:0] exp_ext_q[$];
  logic [32:0] exp_thrd_q[$];

  cpu_dispatcher cpu_dispatcher_inst (.*);

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      abort_run($sformatf("ERROR %s expected 0x%0h got 0x%0h", name, want, got));
    end
  endtask

  // initial memory contents, built from every address bit
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a[7:0], a[15:8]} ^ (a * 16'h9E37) ^ 16'h5A3C;
  endfunction

  // start slot every other poll while an idle cpu exists
  function automatic logic [CPU_INDEX_W-1:0] roster_next_index(input int active,
      input int nonactive, input int rr, input bit offered);
    int nxt;
    if (nonactive > 0 && !offered) begin
      return CPU_NONACTIVE;
    end
    nxt = rr + 1;
    if (nxt >= active) begin
      nxt = 0;
    end
    return 8'(nxt) | CPU_ACTIVE;
  endfunction

  // next running slot after ptr, ptr itself last
  function automatic int rotate_ptr(input int ptr, input logic [THREAD_SLOTS-1:0] running);
    int cand;
    for (int step = 1; step <= THREAD_SLOTS; step++) begin
      cand = (ptr + step) % THREAD_SLOTS;
      if (running[cand]) begin
        return cand;
      end
    end
    return ptr;
  endfunction

  // advance both models by one poll and queue what that poll shows
  task automatic expect_next_poll();
    logic [CPU_INDEX_W-1:0] idx;
    logic [ADDR_W-1:0]      entry;
    idx = roster_next_index(m_active, m_nonactive, m_rr, m_offered);
    if (idx == CPU_NONACTIVE) begin
      m_offered = 1'b1;
    end else begin
      m_rr      = int'(idx[6:0]);
      m_offered = 1'b0;
    end
    m_last_index = idx;
    m_ptr        = rotate_ptr(m_ptr, m_running);
    entry        = m_running[m_ptr] ? m_entry[m_ptr] : 16'h0;
    exp_poll_q.push_back({9'h0, idx, entry});
  endtask

  task automatic wait_for_poll();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > POLL_TIMEOUT) begin
        abort_run("timeout waiting for cpu_q");
      end
    end while (!cpu_q);
  endtask

  // memory answers after a delay chosen by the stimulus
  always @(negedge clk) begin : memory_model
    ext_read_dn  <= 1'b0;
    ext_write_dn <= 1'b0;
    if (ext_rst_e) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        ext_mem[i] = fill_word(16'(i));
      end
      mem_busy = 1'b0;
    end else if (ext_read_q || ext_write_q) begin
      mem_busy  = 1'b1;
      mem_write = ext_write_q;
      mem_wait  = mem_delay;
    end else if (mem_busy) begin
      if (mem_wait == 0) begin
        if (mem_write) begin
          ext_mem[ext_mem_addr_out[3:0]] = ext_mem_data_out;
        end
        ext_mem_addr_in <= ext_mem_addr_out;
        ext_mem_data_in <= ext_mem[ext_mem_addr_out[3:0]];
        ext_read_dn     <= !mem_write;
        ext_write_dn    <= mem_write;
        mem_busy = 1'b0;
      end else begin
        mem_wait--;
      end
    end
  end

  // outputs sampled mid-cycle, away from the rising edge
  always @(negedge clk) begin : compare
    logic [32:0] e;
    if (ext_rst_e) begin
      check_value("cpu_q", 32'(cpu_q), 32'h0);
      check_value("read_dn", 32'(read_dn), 32'h0);
      check_value("write_dn", 32'(write_dn), 32'h0);
      check_value("ext_read_q", 32'(ext_read_q), 32'h0);
      check_value("ext_write_q", 32'(ext_write_q), 32'h0);
      check_value("cpu_msg_out", 32'(cpu_msg_out), 32'h0);
      check_value("data_out", 32'(data_out), 32'h0);
      check_value("addr_out", 32'(addr_out), 32'h0);
    end else begin
      if (cpu_q) begin
        if (exp_poll_q.size() == 0) abort_run("cpu_q pulsed with no poll expected");
        e = exp_poll_q.pop_front();
        check_value("cpu_index", 32'(cpu_index), 32'(e[23:16]));
        check_value("addr_out", 32'(addr_out), 32'(e[15:0]));
      end
      if (ext_read_q || ext_write_q) begin
        if (exp_ext_q.size() == 0) abort_run("memory strobe with no request issued");
        e = exp_ext_q.pop_front();
        check_value("ext_write_q", 32'(ext_write_q), 32'(e[32]));
        check_value("ext_mem_addr_out", 32'(ext_mem_addr_out), 32'(e[31:16]));
        if (ext_write_q) begin
          check_value("ext_mem_data_out", 32'(ext_mem_data_out), 32'(e[15:0]));
        end
      end
      if (read_dn || write_dn) begin
        if (exp_mem_q.size() == 0) abort_run("memory done with no request issued");
        e = exp_mem_q.pop_front();
        check_value("write_dn", 32'(write_dn), 32'(e[32]));
        check_value("addr_out", 32'(addr_out), 32'(e[31:16]));
        check_value("data_out", 32'(data_out), 32'(e[15:0]));
      end
      if (cpu_msg_out == CPU_R_FORK_DONE || cpu_msg_out == CPU_R_STOP_DONE) begin
        if (exp_thrd_q.size() == 0) abort_run("thread reply with no command issued");
        e = exp_thrd_q.pop_front();
        check_value("cpu_msg_out", 32'(cpu_msg_out), 32'(e[19:16]));
        // only a fork echoes data
        if (e[32]) begin
          check_value("data_out", 32'(data_out), 32'(e[15:0]));
        end
      end
    end
  end

  initial begin : stimulus
    int                kind;
    int                idle;
    int                slot;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] word;
    seed        = 32'h5d20034f;
    ext_rst_e   = 1'b1;
    cpu_e       = 1'b0;
    cpu_msg_in  = CPU_R_NULL;
    addr_in     = '0;
    data_in     = '0;
    read_q      = 1'b0;
    write_q     = 1'b0;
    mem_delay   = 0;
    m_active    = 0;
    m_nonactive = CPU_QUANTITY;
    m_rr        = 0;
    m_offered   = 1'b0;
    m_ptr       = 0;
    m_running   = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(16'(i));
    end
    repeat (RESET_CYCLES) @(negedge clk);
    ext_rst_e <= 1'b0;
    expect_next_poll();
    for (int n = 0; n < NUM_OPS; n++) begin
      wait_for_poll();
      // cpu takes a while to answer
      idle = $unsigned($random(seed)) % 3;
      repeat (idle) @(negedge clk);
      kind      = $unsigned($random(seed)) % 6;
      addr      = 16'($unsigned($random(seed)) % MEM_WORDS);
      word      = 16'($random(seed));
      slot      = $unsigned($random(seed)) % THREAD_SLOTS;
      mem_delay = $unsigned($random(seed)) % 5;
      case (kind)
        0: begin
          read_q  <= 1'b1;
          addr_in <= addr;
          exp_ext_q.push_back({1'b0, addr, 16'h0});
          exp_mem_q.push_back({1'b0, addr, ref_mem[addr[3:0]]});
        end
        1: begin
          write_q <= 1'b1;
          addr_in <= addr;
          data_in <= word;
          ref_mem[addr[3:0]] = word;
          exp_ext_q.push_back({1'b1, addr, word});
          exp_mem_q.push_back({1'b1, addr, word});
        end
        2: begin
          // fork, slot on the address bus and entry on the data bus
          cpu_msg_in <= CPU_R_FORK_THRD;
          addr_in    <= 16'(slot);
          data_in    <= word;
          m_running[slot] = 1'b1;
          m_entry[slot]   = word;
          exp_thrd_q.push_back({1'b1, 12'h0, CPU_R_FORK_DONE, word});
        end
        3: begin
          cpu_msg_in <= CPU_R_STOP_THRD;
          addr_in    <= 16'(slot);
          m_running[slot] = 1'b0;
          exp_thrd_q.push_back({1'b0, 12'h0, CPU_R_STOP_DONE, 16'h0});
        end
        default: begin
          // idle cpu takes a start slot, active cpu ends
          cpu_e <= 1'b1;
          if (m_last_index == CPU_NONACTIVE) begin
            cpu_msg_in <= CPU_R_START;
            if (m_nonactive > 0) begin
              m_nonactive--;
              m_active++;
            end
          end else begin
            cpu_msg_in <= CPU_R_END;
            if (m_active > 0) begin
              m_active--;
              m_nonactive++;
            end
          end
        end
      endcase
      @(negedge clk);
      read_q     <= 1'b0;
      write_q    <= 1'b0;
      cpu_e      <= 1'b0;
      cpu_msg_in <= CPU_R_NULL;
      expect_next_poll();
    end
    wait_for_poll();
    @(negedge clk);
    if (exp_poll_q.size() == 0 && exp_mem_q.size() == 0 &&
        exp_ext_q.size() == 0 && exp_thrd_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("some expected responses never arrived");
      $display("Test failed");
      $fatal(1, "incomplete run");
    end
  end

endmodule

//--- thread_table.sv
`timescale 1ns/1ps

module thread_table
  import dispatch_pkg::*;
  import cpu_msg_pkg::*;
(
  input  logic      clk,
  input  logic      ext_rst_e,
  thread_if.target  ctl,
  return_if.source  ret
);

  logic [ADDR_W-1:0]       entry_q [THREAD_SLOTS];
  logic [THREAD_SLOTS-1:0] running;
  logic [SLOT_W-1:0]       ptr;
  logic [SLOT_W-1:0]       next_ptr;
  logic [SLOT_W-1:0]       cand;
  logic                    found;
  logic                    done_r;
  logic                    reply_r;
  cpu_msg_t                reply_msg;
  logic [DATA_W-1:0]       reply_data;
  logic [SLOT_W-1:0]       reply_slot;

  // first running slot after ptr, ptr itself checked last
  always_comb begin
    next_ptr = ptr;
    found    = 1'b0;
    cand     = ptr;
    for (int i = 1; i <= THREAD_SLOTS; i++) begin
      cand = ptr + SLOT_W'(i);
      if (!found && running[cand]) begin
        next_ptr = cand;
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      running <= '0;
      ptr     <= '0;
      done_r  <= 1'b0;
      reply_r <= 1'b0;
    end else begin
      done_r  <= ctl.cmd != THREAD_CMD_NULL;
      // reply one cycle behind done
      reply_r <= done_r;
      if (ctl.advance) begin
        ptr <= next_ptr;
      end
      if (ctl.cmd == THREAD_CMD_RUN) begin
        running[ctl.slot] <= 1'b1;
      end else if (ctl.cmd == THREAD_CMD_STOP) begin
        running[ctl.slot] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.cmd != THREAD_CMD_NULL) begin
      reply_slot <= ctl.slot;
      reply_msg  <= (ctl.cmd == THREAD_CMD_RUN) ? CPU_R_FORK_DONE : CPU_R_STOP_DONE;
      // fork echoes its entry, stop returns zero
      reply_data <= (ctl.cmd == THREAD_CMD_RUN) ? DATA_W'(ctl.entry) : '0;
    end
    if (ctl.cmd == THREAD_CMD_RUN) begin
      entry_q[ctl.slot] <= ctl.entry;
    end
  end

  assign ctl.done       = done_r;
  assign ctl.next_entry = running[ptr] ? entry_q[ptr] : '0;

  assign ret.valid = reply_r;
  assign ret.addr  = ADDR_W'(reply_slot);
  assign ret.data  = reply_data;
  assign ret.msg   = reply_msg;

endmodule
